// File: bench/tb_data_cache.sv
`timescale 1ns/1ps

module tb_data_cache;

    // rdy is seen at the third falling edge after the command is set up
    localparam int HIT_CYCLES = 3;
    localparam int TIMEOUT    = 400;

    logic                 clk;
    logic                 rst;
    cache_pkg::host_req_t req;
    cache_pkg::host_rsp_t rsp;
    cache_pkg::ddr_cmd_t  ddr_cmd;
    cache_pkg::ddr_beat_t ddr_rd;
    cache_pkg::ddr_beat_t ddr_wr;

    integer               seed = 61288;
    integer               gap_seed = 61289;
    logic [31:0]          rnd;
    logic [31:0]          rnd2;
    logic [31:0]          gap_rnd;
    int                   pick;
    int                   rd_count;
    int                   wr_count;
    cache_pkg::word_t     ddr_mem [65536];

    // reference copy of the cached line
    cache_pkg::addr_t     m_tag;
    logic                 m_valid;
    cache_pkg::word_t     m_line [cache_pkg::LINE_WORDS];

    data_cache_top data_cache_top_i (
        .clk(clk), .rst(rst), .req(req), .rsp(rsp),
        .ddr_cmd(ddr_cmd), .ddr_rd(ddr_rd), .ddr_wr(ddr_wr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic cache_pkg::addr_t word_index(cache_pkg::ddr_addr_t byte_addr, int beat);
        cache_pkg::ddr_addr_t word;
        word = byte_addr / cache_pkg::DDR_ADDR_SCALE + cache_pkg::ddr_addr_t'(beat);
        return word[cache_pkg::ADDR_W-1:0];
    endfunction

    // the DDR responder returns read beats in order with random gaps and stores write beats
    initial begin
        ddr_rd   = '0;
        rd_count = 0;
        wr_count = 0;
        for (int i = 0; i < 65536; i++) begin
            rnd2       = $random(seed);
            ddr_mem[i] = rnd2[15:0];
        end
        forever begin
            @(negedge clk);
            gap_rnd      = $random(gap_seed);
            ddr_rd.valid = 1'b0;
            if (!ddr_cmd.rd_req) begin
                rd_count = 0;
            end else if (rd_count < cache_pkg::LINE_WORDS && gap_rnd[1:0] != 2'd0) begin
                ddr_rd.valid = 1'b1;
                ddr_rd.data  = ddr_mem[word_index(ddr_cmd.addr, rd_count)];
                rd_count++;
            end
            if (!ddr_cmd.wr_req) begin
                wr_count = 0;
            end else if (ddr_wr.valid) begin
                ddr_mem[word_index(ddr_cmd.addr, wr_count)] = ddr_wr.data;
                wr_count++;
            end
        end
    end

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // runs one host command to its rdy pulse and checks it against the line model
    task automatic issue(input cache_pkg::cmd_t cmd, input cache_pkg::addr_t addr,
                         input cache_pkg::offset_t col_sel, input cache_pkg::word_t row_wdata,
                         input cache_pkg::line_bits_t col_wdata);
        logic                  hit;
        logic                  fill;
        logic                  wb;
        logic                  saw_rd;
        cache_pkg::offset_t    off;
        cache_pkg::word_t      exp_row;
        cache_pkg::line_bits_t exp_col;
        cache_pkg::ddr_addr_t  exp_addr;
        int                    cycles;
        int                    beats;
        hit  = m_valid && addr >= m_tag &&
               (addr - m_tag) < cache_pkg::addr_t'(cache_pkg::LINE_WORDS);
        wb   = cmd == cache_pkg::CMD_WRITE_BACK && m_valid;
        fill = cmd != cache_pkg::CMD_WRITE_BACK && !hit;
        // any miss reloads the line starting at the missing word
        if (fill) begin
            m_tag   = addr;
            m_valid = 1'b1;
            for (int i = 0; i < cache_pkg::LINE_WORDS; i++) begin
                m_line[i] = ddr_mem[cache_pkg::addr_t'(addr + i)];
            end
        end
        off      = cache_pkg::offset_t'(addr - m_tag);
        exp_addr = cache_pkg::ddr_addr_t'(m_tag) * cache_pkg::DDR_ADDR_SCALE;
        exp_row  = m_line[off];
        for (int j = 0; j < cache_pkg::LINE_WORDS; j++) begin
            exp_col[j] = m_line[j][col_sel];
        end
        if (cmd == cache_pkg::CMD_ROW_STORE) begin
            m_line[off] = row_wdata;
        end
        if (cmd == cache_pkg::CMD_COL_STORE) begin
            for (int j = 0; j < cache_pkg::LINE_WORDS; j++) begin
                m_line[j][col_sel] = col_wdata[j];
            end
        end
        req.cmd       = cmd;
        req.addr      = addr;
        req.col_sel   = col_sel;
        req.row_wdata = row_wdata;
        req.col_wdata = col_wdata;
        cycles = 0;
        beats  = 0;
        saw_rd = 1'b0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout: no ready pulse from the cache for command %0d", cmd);
                abort_run();
            end
            if (ddr_cmd.rd_req) begin
                saw_rd = 1'b1;
                check_value("ddr_cmd.addr", 32'(ddr_cmd.addr), 32'(exp_addr));
            end
            if (!fill) begin
                check_value("rd_req", 32'(ddr_cmd.rd_req), 0);
            end
            if (!wb) begin
                check_value("wr_req", 32'(ddr_cmd.wr_req), 0);
            end
            // write beats must follow each other without a gap
            if (wb && beats > 0) begin
                check_value("ddr_wr.valid", 32'(ddr_wr.valid),
                            32'(beats < cache_pkg::LINE_WORDS));
            end
            if (ddr_wr.valid) begin
                check_value("ddr_cmd.addr", 32'(ddr_cmd.addr), 32'(exp_addr));
                check_value("ddr_wr.data", 32'(ddr_wr.data), 32'(m_line[beats]));
                beats++;
            end
        end while (!rsp.rdy);
        req.cmd = cache_pkg::CMD_NONE;
        if (!fill && !wb) begin
            check_value("rdy delay", cycles, HIT_CYCLES);
        end
        if (fill) begin
            check_value("rd_req seen", 32'(saw_rd), 1);
        end
        if (wb) begin
            check_value("ddr_wr beats", beats, cache_pkg::LINE_WORDS);
            for (int i = 0; i < cache_pkg::LINE_WORDS; i++) begin
                check_value("ddr memory word", 32'(ddr_mem[cache_pkg::addr_t'(m_tag + i)]),
                            32'(m_line[i]));
            end
        end
        if (cmd == cache_pkg::CMD_ROW_LOAD) begin
            check_value("row_rdata", 32'(rsp.row_rdata), 32'(exp_row));
        end
        if (cmd == cache_pkg::CMD_COL_LOAD) begin
            check_value("col_rdata", 32'(rsp.col_rdata), 32'(exp_col));
        end
        @(negedge clk);
        check_value("rdy", 32'(rsp.rdy), 0);
    endtask

    initial begin
        rst     = 1'b0;
        req     = '0;
        m_tag   = '0;
        m_valid = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_value("rdy", 32'(rsp.rdy), 0);
        check_value("rd_req", 32'(ddr_cmd.rd_req), 0);
        check_value("wr_req", 32'(ddr_cmd.wr_req), 0);
        check_value("ddr_wr.valid", 32'(ddr_wr.valid), 0);

        // the tag is still invalid, so no burst goes out
        issue(cache_pkg::CMD_WRITE_BACK, 16'd0, 4'd0, 16'h0, 16'h0);
        issue(cache_pkg::CMD_ROW_LOAD, 16'd100, 4'd0, 16'h0, 16'h0);
        issue(cache_pkg::CMD_ROW_LOAD, 16'd105, 4'd0, 16'h0, 16'h0);
        issue(cache_pkg::CMD_ROW_STORE, 16'd103, 4'd0, 16'hbeef, 16'h0);
        issue(cache_pkg::CMD_ROW_LOAD, 16'd103, 4'd0, 16'h0, 16'h0);
        issue(cache_pkg::CMD_ROW_STORE, 16'd400, 4'd0, 16'h1234, 16'h0);
        issue(cache_pkg::CMD_COL_STORE, 16'd402, 4'd5, 16'h0, 16'ha5c3);
        issue(cache_pkg::CMD_COL_LOAD, 16'd410, 4'd5, 16'h0, 16'h0);
        for (int i = 0; i < 4; i++) begin
            issue(cache_pkg::CMD_ROW_LOAD, cache_pkg::addr_t'(400 + i), 4'd0, 16'h0, 16'h0);
        end
        issue(cache_pkg::CMD_WRITE_BACK, 16'd0, 4'd0, 16'h0, 16'h0);

        // a narrow address window mixes hits, misses and write-backs
        for (int n = 0; n < 300; n++) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            pick = int'(rnd[7:0]) % 5 + 1;
            issue(cache_pkg::cmd_t'(pick[2:0]), cache_pkg::addr_t'(200 + int'(rnd[13:8])),
                  rnd[17:14], rnd[31:16], rnd2[15:0]);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: hdl/access_ctrl.sv
`timescale 1ns/1ps

module access_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::host_req_t  req,
    input  logic                  hit,
    input  cache_pkg::offset_t    offset,
    input  cache_pkg::addr_t      tag,
    input  logic                  tag_valid,
    input  logic                  fill_done,
    input  logic                  wb_done,
    input  cache_pkg::word_t      row_rdata,
    input  cache_pkg::line_bits_t col_rdata,
    output logic                  fill_start,
    output logic                  wb_start,
    output cache_pkg::addr_t      base_addr,
    output logic                  tag_load,
    output cache_pkg::array_op_t  op,
    output cache_pkg::host_rsp_t  rsp
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        ACCESS,
        FILL,
        WRITE_BACK
    } state_t;

    state_t               state;
    state_t               state_nxt;
    logic                 rdy_q;
    logic                 is_wb;
    cache_pkg::array_op_t op_dec;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
            rdy_q <= 1'b0;
        end else begin
            state <= state_nxt;
            rdy_q <= (state == ACCESS) || (state == WRITE_BACK && wb_done);
        end
    end

    assign is_wb = req.cmd == cache_pkg::CMD_WRITE_BACK;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // the host still holds the old command while rdy is high
                if (req.cmd != cache_pkg::CMD_NONE && !rdy_q) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (is_wb) begin
                    state_nxt = tag_valid ? WRITE_BACK : ACCESS;
                end else begin
                    state_nxt = hit ? ACCESS : FILL;
                end
            end
            ACCESS: state_nxt = IDLE;
            FILL: begin
                if (fill_done) begin
                    state_nxt = LOOKUP;
                end
            end
            WRITE_BACK: begin
                if (wb_done) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_comb begin
        case (req.cmd)
            cache_pkg::CMD_ROW_LOAD:  op_dec = cache_pkg::OP_ROW_READ;
            cache_pkg::CMD_ROW_STORE: op_dec = cache_pkg::OP_ROW_WRITE;
            cache_pkg::CMD_COL_LOAD:  op_dec = cache_pkg::OP_COL_READ;
            cache_pkg::CMD_COL_STORE: op_dec = cache_pkg::OP_COL_WRITE;
            default:                  op_dec = cache_pkg::OP_IDLE;
        endcase
    end

    // a store miss fills first and then writes the refilled line
    assign fill_start = (state == LOOKUP) && !is_wb && !hit;
    assign wb_start   = (state == LOOKUP) && is_wb && tag_valid;
    assign tag_load   = (state == FILL) && fill_done;
    assign base_addr  = is_wb ? tag : req.addr;
    assign op         = (state == ACCESS) ? op_dec : cache_pkg::OP_IDLE;

    assign rsp.rdy       = rdy_q;
    assign rsp.row_rdata = row_rdata;
    assign rsp.col_rdata = col_rdata;

    // a fresh line starts at the missing address, so the retry hits word 0
    refill_hits_first_word: assert property (
        @(posedge clk) disable iff (!rst) tag_load |=> hit && offset == '0
    );

endmodule

// File: hdl/burst_engine.sv
`timescale 1ns/1ps

module burst_engine (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fill_start,
    input  logic                 wb_start,
    input  cache_pkg::addr_t     base_addr,
    output cache_pkg::ddr_cmd_t  ddr_cmd,
    input  cache_pkg::ddr_beat_t ddr_rd,
    output cache_pkg::ddr_beat_t ddr_wr,
    output logic                 fill_we,
    output cache_pkg::offset_t   fill_index,
    output cache_pkg::word_t     fill_data,
    output cache_pkg::offset_t   wb_index,
    input  cache_pkg::word_t     wb_word,
    output logic                 fill_done,
    output logic                 wb_done
);

    logic                  busy;
    logic                  wb_dir;
    logic                  wr_valid_q;
    logic                  wr_last_q;
    logic                  fill_done_q;
    logic                  last_beat;
    cache_pkg::offset_t    beat;
    cache_pkg::ddr_addr_t  addr_q;

    assign last_beat = beat == cache_pkg::offset_t'(cache_pkg::LINE_WORDS - 1);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy        <= 1'b0;
            wb_dir      <= 1'b0;
            beat        <= '0;
            wr_valid_q  <= 1'b0;
            wr_last_q   <= 1'b0;
            fill_done_q <= 1'b0;
        end else begin
            fill_done_q <= 1'b0;
            // array read data lags the index by one cycle, so the beat does too
            wr_valid_q  <= busy && wb_dir;
            wr_last_q   <= busy && wb_dir && last_beat;
            if (fill_start || wb_start) begin
                busy   <= 1'b1;
                wb_dir <= wb_start;
                beat   <= '0;
            end else if (busy && (wb_dir || ddr_rd.valid)) begin
                beat <= beat + 1'b1;
                if (last_beat) begin
                    busy        <= 1'b0;
                    fill_done_q <= !wb_dir;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_start || wb_start) begin
            addr_q <= cache_pkg::ddr_addr_t'(base_addr) * cache_pkg::DDR_ADDR_SCALE;
        end
    end

    assign ddr_cmd.rd_req = busy && !wb_dir;
    assign ddr_cmd.wr_req = (busy && wb_dir) || wr_valid_q;
    assign ddr_cmd.addr   = addr_q;

    assign ddr_wr.valid = wr_valid_q;
    assign ddr_wr.data  = wb_word;

    // incoming beats land in the line in arrival order
    assign fill_we    = busy && !wb_dir && ddr_rd.valid;
    assign fill_index = beat;
    assign fill_data  = ddr_rd.data;
    assign wb_index   = beat;

    assign fill_done = fill_done_q;
    assign wb_done   = wr_valid_q && wr_last_q;

    start_only_when_idle: assert property (
        @(posedge clk) disable iff (!rst)
        (fill_start || wb_start) |-> !(busy || wr_valid_q)
    );

    one_direction_at_a_time: assert property (
        @(posedge clk) disable iff (!rst) !(ddr_cmd.rd_req && ddr_cmd.wr_req)
    );

endmodule

// File: hdl/cache_pkg.sv
package cache_pkg;

    // one line holds 16 words and is also one DDR burst
    localparam int WORD_W     = 16;
    localparam int LINE_WORDS = 16;
    localparam int OFFSET_W   = 4;
    localparam int ADDR_W     = 16;
    localparam int DDR_ADDR_W = 28;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [OFFSET_W-1:0]   offset_t;
    typedef logic [LINE_WORDS-1:0] line_bits_t;
    typedef logic [DDR_ADDR_W-1:0] ddr_addr_t;

    // a host word maps onto 8 DDR byte addresses
    localparam ddr_addr_t DDR_ADDR_SCALE = 8;

    typedef enum logic [2:0] {
        CMD_NONE       = 3'd0,
        CMD_ROW_LOAD   = 3'd1,
        CMD_ROW_STORE  = 3'd2,
        CMD_COL_LOAD   = 3'd3,
        CMD_COL_STORE  = 3'd4,
        CMD_WRITE_BACK = 3'd5
    } cmd_t;

    typedef struct packed {
        cmd_t       cmd;
        addr_t      addr;
        offset_t    col_sel;
        word_t      row_wdata;
        line_bits_t col_wdata;
    } host_req_t;

    typedef struct packed {
        logic       rdy;
        word_t      row_rdata;
        line_bits_t col_rdata;
    } host_rsp_t;

    typedef struct packed {
        logic      rd_req;
        logic      wr_req;
        ddr_addr_t addr;
    } ddr_cmd_t;

    // same beat format in both directions
    typedef struct packed {
        logic  valid;
        word_t data;
    } ddr_beat_t;

    typedef enum logic [2:0] {
        OP_IDLE,
        OP_ROW_READ,
        OP_ROW_WRITE,
        OP_COL_READ,
        OP_COL_WRITE
    } array_op_t;

endpackage

// File: hdl/data_cache_top.sv
`timescale 1ns/1ps

module data_cache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  cache_pkg::host_req_t req,
    output cache_pkg::host_rsp_t rsp,
    output cache_pkg::ddr_cmd_t  ddr_cmd,
    input  cache_pkg::ddr_beat_t ddr_rd,
    output cache_pkg::ddr_beat_t ddr_wr
);

    logic                  hit;
    logic                  tag_valid;
    logic                  tag_load;
    logic                  fill_start;
    logic                  wb_start;
    logic                  fill_done;
    logic                  wb_done;
    logic                  fill_we;
    cache_pkg::offset_t    offset;
    cache_pkg::offset_t    fill_index;
    cache_pkg::offset_t    wb_index;
    cache_pkg::addr_t      tag;
    cache_pkg::addr_t      base_addr;
    cache_pkg::word_t      fill_data;
    cache_pkg::word_t      wb_word;
    cache_pkg::word_t      row_rdata;
    cache_pkg::line_bits_t col_rdata;
    cache_pkg::array_op_t  op;

    tag_check tag_check_i (
        .clk(clk), .rst(rst), .addr(req.addr), .tag_load(tag_load),
        .hit(hit), .offset(offset), .tag(tag), .tag_valid(tag_valid)
    );

    burst_engine burst_engine_i (
        .clk(clk), .rst(rst), .fill_start(fill_start), .wb_start(wb_start),
        .base_addr(base_addr), .ddr_cmd(ddr_cmd), .ddr_rd(ddr_rd), .ddr_wr(ddr_wr),
        .fill_we(fill_we), .fill_index(fill_index), .fill_data(fill_data),
        .wb_index(wb_index), .wb_word(wb_word), .fill_done(fill_done), .wb_done(wb_done)
    );

    line_array line_array_i (
        .clk(clk), .op(op), .offset(offset), .col_sel(req.col_sel),
        .row_wdata(req.row_wdata), .col_wdata(req.col_wdata), .fill_we(fill_we),
        .fill_index(fill_index), .fill_data(fill_data), .wb_index(wb_index),
        .wb_word(wb_word), .row_rdata(row_rdata), .col_rdata(col_rdata)
    );

    access_ctrl access_ctrl_i (
        .clk(clk), .rst(rst), .req(req), .hit(hit), .offset(offset), .tag(tag),
        .tag_valid(tag_valid), .fill_done(fill_done), .wb_done(wb_done),
        .row_rdata(row_rdata), .col_rdata(col_rdata), .fill_start(fill_start),
        .wb_start(wb_start), .base_addr(base_addr), .tag_load(tag_load), .op(op), .rsp(rsp)
    );

endmodule

// File: hdl/line_array.sv
`timescale 1ns/1ps

module line_array (
    input  logic                  clk,
    input  cache_pkg::array_op_t  op,
    input  cache_pkg::offset_t    offset,
    input  cache_pkg::offset_t    col_sel,
    input  cache_pkg::word_t      row_wdata,
    input  cache_pkg::line_bits_t col_wdata,
    input  logic                  fill_we,
    input  cache_pkg::offset_t    fill_index,
    input  cache_pkg::word_t      fill_data,
    input  cache_pkg::offset_t    wb_index,
    output cache_pkg::word_t      wb_word,
    output cache_pkg::word_t      row_rdata,
    output cache_pkg::line_bits_t col_rdata
);

    cache_pkg::word_t mem [cache_pkg::LINE_WORDS];

    // read data holds until the next read of the same kind
    always_ff @(posedge clk) begin
        if (fill_we) begin
            mem[fill_index] <= fill_data;
        end
        case (op)
            cache_pkg::OP_ROW_WRITE: begin
                mem[offset] <= row_wdata;
            end
            cache_pkg::OP_COL_WRITE: begin
                // bit j of the column word belongs to line word j
                for (int j = 0; j < cache_pkg::LINE_WORDS; j++) begin
                    mem[j][col_sel] <= col_wdata[j];
                end
            end
            cache_pkg::OP_ROW_READ: begin
                row_rdata <= mem[offset];
            end
            cache_pkg::OP_COL_READ: begin
                for (int j = 0; j < cache_pkg::LINE_WORDS; j++) begin
                    col_rdata[j] <= mem[j][col_sel];
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        wb_word <= mem[wb_index];
    end

    no_fill_during_host_write: assert property (
        @(posedge clk)
        !(fill_we && (op == cache_pkg::OP_ROW_WRITE || op == cache_pkg::OP_COL_WRITE))
    );

endmodule

// File: hdl/tag_check.sv
`timescale 1ns/1ps

module tag_check (
    input  logic               clk,
    input  logic               rst,
    input  cache_pkg::addr_t   addr,
    input  logic               tag_load,
    output logic               hit,
    output cache_pkg::offset_t offset,
    output cache_pkg::addr_t   tag,
    output logic               tag_valid
);

    cache_pkg::addr_t tag_q;
    cache_pkg::addr_t diff;
    logic             valid_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tag_q   <= '0;
            valid_q <= 1'b0;
        end else if (tag_load) begin
            tag_q   <= addr;
            valid_q <= 1'b1;
        end
    end

    // the line covers tag .. tag + LINE_WORDS - 1, so an address below the
    // tag must not wrap around into a false hit
    assign diff      = addr - tag_q;
    assign hit       = valid_q && (addr >= tag_q) &&
                       (diff < cache_pkg::addr_t'(cache_pkg::LINE_WORDS));
    assign offset    = diff[cache_pkg::OFFSET_W-1:0];
    assign tag       = tag_q;
    assign tag_valid = valid_q;

    // the line is only reloaded for an address that it does not cover yet
    reload_only_on_miss: assert property (
        @(posedge clk) disable iff (!rst) tag_load |-> !hit
    );

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f verilog.f \
        --top-module tb_data_cache -o sim_data_cache \
    && ./obj_dir/sim_data_cache \
    || exit 1

// File: verilog.f
hdl/cache_pkg.sv
hdl/tag_check.sv
hdl/burst_engine.sv
hdl/line_array.sv
hdl/access_ctrl.sv
hdl/data_cache_top.sv
bench/tb_data_cache.sv
